/* src/kcpu_settings.svh */
// kcpu stack unit settings
// condition flag positions and clock enable ratio
`ifndef KCPU_SETTINGS_SVH
`define KCPU_SETTINGS_SVH

// bit positions inside CC
`define KCPU_CC_E 7 // entire state saved
`define KCPU_CC_F 6 // fast irq mask
`define KCPU_CC_I 4 // irq mask

// clocks per cen period
// cen and cen2 sit on opposite phases, one byte moves per period
`define KCPU_CEN_DIV 2

`endif

/* src/kcpu_pkg.sv */
// kcpu shared types
// register widths, command and snapshot structs, stack FSM states
package kcpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // bit 7..0 = PC, U/S (other pointer), Y, X, DP, B, A, CC
    typedef logic [7:0] psh_mask_t;

    // 0=A 1=B 2=X 3=Y 4=S 5=U, 6 and 7 select nothing
    typedef logic [2:0] reg_code_t;

    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_LOAD,
        CMD_TFR,
        CMD_EXG,
        CMD_IDX,
        CMD_PUSH,
        CMD_PULL,
        CMD_SETF
    } cmd_kind_e;

    typedef struct packed {
        cmd_kind_e kind;
        reg_code_t dst;
        reg_code_t src;
        psh_mask_t mask;
        logic      ussel;    // stack through U instead of S
        logic      idx_post; // post-increment, else pre-decrement
        logic      idx_word; // step by two
        word_t     data;
    } kcpu_cmd_t;

    typedef struct packed {
        byte_t a;
        byte_t b;
        byte_t dp;
        byte_t cc;
        word_t x;
        word_t y;
        word_t u;
        word_t s;
        word_t pc_out; // last pulled PC
    } reg_snap_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_EXEC,
        ST_WALK,
        ST_MEM_WAIT,
        ST_DONE
    } stack_state_e;

endpackage

/* src/kcpu_cen_timer.sv */
// kcpu clock enable generator
// splits clk into alternating cen and cen2 phases
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_cen_timer (
    input  logic clk,
    input  logic rst,
    output logic cen,
    output logic cen2
);

    localparam int div = `KCPU_CEN_DIV;
    localparam int cw  = $clog2(div);
    localparam logic [cw-1:0] last_ph = cw'(div - 1);
    localparam logic [cw-1:0] half_ph = cw'(div / 2 - 1);

    logic [cw-1:0] cnt; // phase within the period

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            cen  <= 1'b0;
            cen2 <= 1'b0;
        end else begin
            cnt  <= (cnt == last_ph) ? '0 : cnt + 1'b1;
            cen  <= cnt == last_ph;
            cen2 <= cnt == half_ph; // opposite half of the period
        end
    end

endmodule

/* src/kcpu_mask_walk.sv */
// kcpu push/pull mask walker
// picks the next register of the mask and tracks which byte half moves
`timescale 1ns/1ps

module kcpu_mask_walk (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen2,
    input  logic                ld_mask,
    input  logic                step,
    input  kcpu_pkg::psh_mask_t mask_in,
    input  logic                pull,
    output kcpu_pkg::psh_mask_t cur_bit,
    output logic                hihalf,
    output logic                empty
);

    kcpu_pkg::psh_mask_t rem; // registers still to move
    logic dir_pull;
    logic wide;

    // push goes from bit 7 down, pull from bit 0 up
    always_comb begin
        cur_bit = '0;
        if (dir_pull) begin
            cur_bit = rem & (~rem + 8'd1); // lowest set bit
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (rem[i]) cur_bit = 8'd1 << i; // last hit is the highest
            end
        end
    end

    assign wide  = |cur_bit[7:4]; // PC, U/S, Y, X
    assign empty = rem == '0;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rem      <= '0;
            hihalf   <= 1'b0;
            dir_pull <= 1'b0;
        end else if (ld_mask) begin
            rem      <= mask_in;
            dir_pull <= pull;
            hihalf   <= pull; // pull starts on the high byte
        end else if (step && cen2 && !empty) begin
            if (wide && hihalf == dir_pull) begin
                hihalf <= !hihalf; // first half done
            end else begin
                rem    <= rem & ~cur_bit;
                hihalf <= dir_pull;
            end
        end
    end

endmodule

/* src/kcpu_stack_fsm.sv */
// kcpu stack sequencer
// runs one-shot commands and the byte loop of push and pull
`timescale 1ns/1ps

module kcpu_stack_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                start,
    input  kcpu_pkg::kcpu_cmd_t cmd,
    input  logic                empty,
    output kcpu_pkg::kcpu_cmd_t cmd_q,
    output logic                exec,
    output logic                ld_mask,
    output logic                step,
    output logic                psh_dec,
    output logic                pul_en,
    output logic                mem_we,
    output logic                busy
);

    kcpu_pkg::stack_state_e state;
    logic accept;
    logic stack_cmd;
    logic is_push;
    logic byte_go;

    // DONE lasts one clock and already takes a new start
    assign busy = state == kcpu_pkg::ST_EXEC || state == kcpu_pkg::ST_WALK ||
                  state == kcpu_pkg::ST_MEM_WAIT;
    assign accept    = start && !busy; // starts while busy are dropped
    assign stack_cmd = cmd.kind == kcpu_pkg::CMD_PUSH || cmd.kind == kcpu_pkg::CMD_PULL;
    assign ld_mask   = accept && stack_cmd; // walker loads with the start
    assign is_push   = cmd_q.kind == kcpu_pkg::CMD_PUSH;

    assign exec    = state == kcpu_pkg::ST_EXEC && cen;
    assign byte_go = state == kcpu_pkg::ST_WALK && !empty && cen;
    assign psh_dec = byte_go && is_push;
    assign pul_en  = byte_go && !is_push;
    assign step    = state == kcpu_pkg::ST_MEM_WAIT; // lands on the cen2 phase

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= kcpu_pkg::ST_IDLE;
            cmd_q  <= '0;
            mem_we <= 1'b0;
        end else begin
            // push byte is latched on cen2, so the write follows MEM_WAIT
            mem_we <= state == kcpu_pkg::ST_MEM_WAIT && is_push;
            case (state)
                kcpu_pkg::ST_IDLE, kcpu_pkg::ST_DONE: begin
                    if (accept) begin
                        cmd_q <= cmd;
                        state <= stack_cmd ? kcpu_pkg::ST_WALK : kcpu_pkg::ST_EXEC;
                    end else begin
                        state <= kcpu_pkg::ST_IDLE;
                    end
                end
                kcpu_pkg::ST_EXEC: begin
                    if (cen) state <= kcpu_pkg::ST_DONE; // result lands now
                end
                kcpu_pkg::ST_WALK: begin
                    if (empty) begin
                        state <= kcpu_pkg::ST_DONE; // last write, if any, lands now
                    end else if (cen) begin
                        state <= kcpu_pkg::ST_MEM_WAIT;
                    end
                end
                kcpu_pkg::ST_MEM_WAIT: state <= kcpu_pkg::ST_WALK;
                default: state <= kcpu_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

/* src/kcpu_regs.sv */
// kcpu register file
// A, B, DP, CC, X, Y, U, S with transfer/exchange, index steps and stack data
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                cen2,
    input  logic                exec,
    input  kcpu_pkg::kcpu_cmd_t cmd_q,
    input  kcpu_pkg::word_t     pc,
    input  kcpu_pkg::psh_mask_t cur_bit,
    input  logic                hihalf,
    input  logic                psh_dec,
    input  logic                pul_en,
    input  kcpu_pkg::byte_t     mem_rdata,
    output kcpu_pkg::word_t     psh_addr,
    output kcpu_pkg::byte_t     psh_byte,
    output kcpu_pkg::reg_snap_t regs
);

    kcpu_pkg::reg_snap_t r;  // register state
    kcpu_pkg::reg_snap_t nx; // next value, taken on cen
    kcpu_pkg::word_t     other; // stack pointer not in use
    kcpu_pkg::word_t     vd;
    kcpu_pkg::word_t     vs;
    kcpu_pkg::word_t     idx_step;
    logic                codes_ok;

    function automatic logic is_wide(kcpu_pkg::reg_code_t c);
        return c >= 3'd2 && c <= 3'd5;
    endfunction

    function automatic kcpu_pkg::word_t get_reg(kcpu_pkg::reg_snap_t v,
                                                kcpu_pkg::reg_code_t c);
        case (c)
            3'd0:    return {8'h00, v.a};
            3'd1:    return {8'h00, v.b};
            3'd2:    return v.x;
            3'd3:    return v.y;
            3'd4:    return v.s;
            3'd5:    return v.u;
            default: return '0;
        endcase
    endfunction

    // a byte fed into a 16-bit register keeps its high half
    function automatic kcpu_pkg::word_t merge(kcpu_pkg::word_t old, kcpu_pkg::word_t val,
                                              logic narrow);
        return narrow ? {old[15:8], val[7:0]} : val;
    endfunction

    function automatic kcpu_pkg::reg_snap_t put_reg(kcpu_pkg::reg_snap_t v,
                                                    kcpu_pkg::reg_code_t c,
                                                    kcpu_pkg::word_t val, logic narrow);
        kcpu_pkg::reg_snap_t t;
        t = v;
        case (c)
            3'd0:    t.a = val[7:0];
            3'd1:    t.b = val[7:0];
            3'd2:    t.x = merge(v.x, val, narrow);
            3'd3:    t.y = merge(v.y, val, narrow);
            3'd4:    t.s = merge(v.s, val, narrow);
            3'd5:    t.u = merge(v.u, val, narrow);
            default: ;
        endcase
        return t;
    endfunction

    function automatic kcpu_pkg::byte_t pick_half(kcpu_pkg::word_t w, logic hi);
        return hi ? w[15:8] : w[7:0];
    endfunction

    function automatic kcpu_pkg::word_t set_half(kcpu_pkg::word_t w, logic hi,
                                                 kcpu_pkg::byte_t d);
        return hi ? {d, w[7:0]} : {w[15:8], d};
    endfunction

    assign psh_addr = cmd_q.ussel ? r.u : r.s;
    assign other    = cmd_q.ussel ? r.s : r.u;
    assign regs     = r;

    assign vd       = get_reg(r, cmd_q.dst);
    assign vs       = get_reg(r, cmd_q.src);
    assign codes_ok = cmd_q.dst < 3'd6 && cmd_q.src < 3'd6; // 6/7 move nothing
    assign idx_step = cmd_q.idx_post ? (cmd_q.idx_word ? 16'd2 : 16'd1)
                                     : (cmd_q.idx_word ? 16'hfffe : 16'hffff);

    always_comb begin
        nx = r;
        if (exec) begin
            case (cmd_q.kind)
                kcpu_pkg::CMD_LOAD: nx = put_reg(nx, cmd_q.dst, cmd_q.data, 1'b0);
                kcpu_pkg::CMD_TFR: begin
                    if (codes_ok) nx = put_reg(nx, cmd_q.dst, vs, !is_wide(cmd_q.src));
                end
                kcpu_pkg::CMD_EXG: begin
                    if (codes_ok) begin
                        nx = put_reg(nx, cmd_q.dst, vs, !is_wide(cmd_q.src));
                        nx = put_reg(nx, cmd_q.src, vd, !is_wide(cmd_q.dst));
                    end
                end
                kcpu_pkg::CMD_IDX: begin
                    if (is_wide(cmd_q.dst)) nx = put_reg(nx, cmd_q.dst, vd + idx_step, 1'b0);
                end
                kcpu_pkg::CMD_SETF: begin
                    nx.cc[`KCPU_CC_E] = r.cc[`KCPU_CC_E] | cmd_q.data[`KCPU_CC_E];
                    nx.cc[`KCPU_CC_F] = r.cc[`KCPU_CC_F] | cmd_q.data[`KCPU_CC_F];
                    nx.cc[`KCPU_CC_I] = r.cc[`KCPU_CC_I] | cmd_q.data[`KCPU_CC_I];
                end
                default: ;
            endcase
        end else if (psh_dec) begin
            // pre-decrement, the write follows on the next cycle
            if (cmd_q.ussel) nx.u = r.u - 16'd1;
            else             nx.s = r.s - 16'd1;
        end else if (pul_en) begin
            if (cmd_q.ussel) nx.u = r.u + 16'd1;
            else             nx.s = r.s + 16'd1;
            case (cur_bit)
                8'h80: nx.pc_out = set_half(r.pc_out, hihalf, mem_rdata);
                8'h40: begin
                    if (cmd_q.ussel) nx.s = set_half(r.s, hihalf, mem_rdata);
                    else             nx.u = set_half(r.u, hihalf, mem_rdata);
                end
                8'h20: nx.y  = set_half(r.y, hihalf, mem_rdata);
                8'h10: nx.x  = set_half(r.x, hihalf, mem_rdata);
                8'h08: nx.dp = mem_rdata;
                8'h04: nx.b  = mem_rdata;
                8'h02: nx.a  = mem_rdata;
                8'h01: nx.cc = mem_rdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            r <= '0;
        end else if (cen) begin
            r <= nx;
        end
    end

    // byte for the next push write
    always_ff @(posedge clk) begin
        if (cen2) begin
            case (cur_bit)
                8'h80:   psh_byte <= pick_half(pc, hihalf);
                8'h40:   psh_byte <= pick_half(other, hihalf);
                8'h20:   psh_byte <= pick_half(r.y, hihalf);
                8'h10:   psh_byte <= pick_half(r.x, hihalf);
                8'h08:   psh_byte <= r.dp;
                8'h04:   psh_byte <= r.b;
                8'h02:   psh_byte <= r.a;
                8'h01:   psh_byte <= r.cc;
                default: psh_byte <= 8'h00;
            endcase
        end
    end

endmodule

/* src/kcpu_stack_unit.sv */
// kcpu stack unit top
// register file with push/pull to a byte-wide memory stack
`timescale 1ns/1ps

module kcpu_stack_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  kcpu_pkg::kcpu_cmd_t cmd,
    input  kcpu_pkg::word_t     pc,
    input  kcpu_pkg::byte_t     mem_rdata,
    output kcpu_pkg::word_t     mem_addr,
    output kcpu_pkg::byte_t     mem_wdata,
    output logic                mem_we,
    output logic                busy,
    output kcpu_pkg::reg_snap_t regs
);

    logic                cen;
    logic                cen2;
    logic                exec;
    logic                ld_mask;
    logic                step;
    logic                psh_dec;
    logic                pul_en;
    logic                hihalf;
    logic                empty;
    kcpu_pkg::kcpu_cmd_t cmd_q;
    kcpu_pkg::psh_mask_t cur_bit;

    kcpu_cen_timer u_timer (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .cen2 (cen2)
    );

    kcpu_stack_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .start   (start),
        .cmd     (cmd),
        .empty   (empty),
        .cmd_q   (cmd_q),
        .exec    (exec),
        .ld_mask (ld_mask),
        .step    (step),
        .psh_dec (psh_dec),
        .pul_en  (pul_en),
        .mem_we  (mem_we),
        .busy    (busy)
    );

    // mask loads in the start cycle, straight from the command
    kcpu_mask_walk u_walk (
        .clk     (clk),
        .rst     (rst),
        .cen2    (cen2),
        .ld_mask (ld_mask),
        .step    (step),
        .mask_in (cmd.mask),
        .pull    (cmd.kind == kcpu_pkg::CMD_PULL),
        .cur_bit (cur_bit),
        .hihalf  (hihalf),
        .empty   (empty)
    );

    kcpu_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .cen2      (cen2),
        .exec      (exec),
        .cmd_q     (cmd_q),
        .pc        (pc),
        .cur_bit   (cur_bit),
        .hihalf    (hihalf),
        .psh_dec   (psh_dec),
        .pul_en    (pul_en),
        .mem_rdata (mem_rdata),
        .psh_addr  (mem_addr),
        .psh_byte  (mem_wdata),
        .regs      (regs)
    );

endmodule

/* verif/kcpu_tb_mem.sv */
// testbench memory, one 256-byte page
// combinational read, byte write on the strobe
`timescale 1ns/1ps

module kcpu_tb_mem (
    input  logic            clk,
    input  logic            we,
    input  kcpu_pkg::word_t addr,
    input  kcpu_pkg::byte_t wdata,
    output kcpu_pkg::byte_t rdata
);

    // high address byte is ignored, the page wraps
    kcpu_pkg::byte_t mem [0:255];

    assign rdata = mem[addr[7:0]]; // answers in the same cycle

    // written mid-cycle while address and data are settled
    always @(negedge clk) begin
        if (we) begin
            mem[addr[7:0]] = wdata;
        end
    end

endmodule

/* verif/kcpu_stack_unit_tb.sv */
// kcpu stack unit testbench
// loads, transfers, index steps, push/pull and flag sets against a reference model
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_stack_unit_tb;

    localparam int max_cmds    = 264;
    localparam int cmd_clks    = 14 * `KCPU_CEN_DIV; // 12-byte push plus start and finish
    localparam int cycle_limit = max_cmds * cmd_clks;
    localparam kcpu_pkg::byte_t flag_mask =
        8'((1 << `KCPU_CC_E) | (1 << `KCPU_CC_F) | (1 << `KCPU_CC_I));

    logic                clk;
    logic                rst;
    logic                start;
    kcpu_pkg::kcpu_cmd_t cmd;
    kcpu_pkg::word_t     pc;
    kcpu_pkg::byte_t     mem_rdata;
    kcpu_pkg::word_t     mem_addr;
    kcpu_pkg::byte_t     mem_wdata;
    logic                mem_we;
    logic                busy;
    kcpu_pkg::reg_snap_t regs;

    kcpu_pkg::reg_snap_t m; // reference registers
    kcpu_pkg::byte_t     ref_mem [0:255];
    kcpu_pkg::word_t     exp_addr_q [$];
    kcpu_pkg::byte_t     exp_data_q [$];
    kcpu_pkg::word_t     wr_addr_q [$]; // writes seen on the bus
    kcpu_pkg::byte_t     wr_data_q [$];
    logic [31:0]         lfsr;
    int                  errors = 0;
    int                  cycles = 0;
    int                  busy_clks;

    kcpu_stack_unit u_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .pc        (pc),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .busy      (busy),
        .regs      (regs)
    );

    kcpu_tb_mem u_mem (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d clocks, a command never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // address and data are stable in the middle of the write cycle
    always @(negedge clk) begin
        if (mem_we === 1'b1) begin
            wr_addr_q.push_back(mem_addr);
            wr_data_q.push_back(mem_wdata);
        end
    end

    assert property (@(posedge clk) disable iff (rst) mem_we |-> busy)
        else begin
            $display("memory write strobe seen while busy is low at %0t", $time);
            errors++;
        end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[14:0], lfsr[0]}; // one step per bit
        end
        return r;
    endfunction

    function automatic kcpu_pkg::byte_t fill_byte(logic [7:0] a);
        return (a * 8'd29) ^ 8'h6c;
    endfunction

    function automatic logic is_wide_code(kcpu_pkg::reg_code_t c);
        return c inside {3'd2, 3'd3, 3'd4, 3'd5};
    endfunction

    function automatic int byte_count(kcpu_pkg::psh_mask_t k);
        return $countones(k[3:0]) + 2 * $countones(k[7:4]);
    endfunction

    function automatic kcpu_pkg::kcpu_cmd_t mk_cmd(kcpu_pkg::cmd_kind_e kind,
                                                   int dst, int src, kcpu_pkg::word_t data);
        kcpu_pkg::kcpu_cmd_t c;
        c      = '0;
        c.kind = kind;
        c.dst  = 3'(dst);
        c.src  = 3'(src);
        c.data = data;
        return c;
    endfunction

    function automatic kcpu_pkg::word_t model_get(kcpu_pkg::reg_code_t c);
        case (c)
            3'd0:    return {8'h00, m.a};
            3'd1:    return {8'h00, m.b};
            3'd2:    return m.x;
            3'd3:    return m.y;
            3'd4:    return m.s;
            3'd5:    return m.u;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic model_put(kcpu_pkg::reg_code_t c, kcpu_pkg::word_t v, logic narrow);
        kcpu_pkg::word_t w;
        w = narrow ? {model_get(c) & 16'hff00} | {8'h00, v[7:0]} : v; // byte keeps high half
        case (c)
            3'd0:    m.a = v[7:0];
            3'd1:    m.b = v[7:0];
            3'd2:    m.x = w;
            3'd3:    m.y = w;
            3'd4:    m.s = w;
            3'd5:    m.u = w;
            default: ;
        endcase
    endtask

    task automatic model_one_shot(kcpu_pkg::kcpu_cmd_t c);
        kcpu_pkg::word_t vd;
        kcpu_pkg::word_t vs;
        logic            ok;
        vd = model_get(c.dst);
        vs = model_get(c.src);
        ok = c.dst < 3'd6 && c.src < 3'd6;
        case (c.kind)
            kcpu_pkg::CMD_LOAD: model_put(c.dst, c.data, 1'b0);
            kcpu_pkg::CMD_TFR:  if (ok) model_put(c.dst, vs, !is_wide_code(c.src));
            kcpu_pkg::CMD_EXG: begin
                if (ok) begin
                    model_put(c.dst, vs, !is_wide_code(c.src));
                    model_put(c.src, vd, !is_wide_code(c.dst));
                end
            end
            kcpu_pkg::CMD_IDX: begin
                if (is_wide_code(c.dst) && c.idx_post)
                    model_put(c.dst, vd + (c.idx_word ? 16'd2 : 16'd1), 1'b0);
                else if (is_wide_code(c.dst))
                    model_put(c.dst, vd - (c.idx_word ? 16'd2 : 16'd1), 1'b0);
            end
            kcpu_pkg::CMD_SETF: m.cc = m.cc | (c.data[7:0] & flag_mask);
            default: ;
        endcase
    endtask

    task automatic model_push(kcpu_pkg::kcpu_cmd_t c);
        kcpu_pkg::word_t p;
        kcpu_pkg::word_t v;
        p = c.ussel ? m.u : m.s;
        for (int i = 7; i >= 0; i--) begin
            if (c.mask[i]) begin
                case (i)
                    7:       v = pc;
                    6:       v = c.ussel ? m.s : m.u; // the other stack pointer
                    5:       v = m.y;
                    4:       v = m.x;
                    3:       v = {8'h00, m.dp};
                    2:       v = {8'h00, m.b};
                    1:       v = {8'h00, m.a};
                    default: v = {8'h00, m.cc};
                endcase
                for (int h = 0; h < ((i >= 4) ? 2 : 1); h++) begin
                    p = p - 16'd1; // low byte first, high byte ends lower
                    ref_mem[p[7:0]] = (h == 0) ? v[7:0] : v[15:8];
                    exp_addr_q.push_back(p);
                    exp_data_q.push_back(ref_mem[p[7:0]]);
                end
            end
        end
        if (c.ussel) m.u = p;
        else         m.s = p;
    endtask

    task automatic model_pull(kcpu_pkg::kcpu_cmd_t c);
        kcpu_pkg::word_t p;
        kcpu_pkg::word_t v;
        p = c.ussel ? m.u : m.s;
        for (int i = 0; i < 8; i++) begin
            if (c.mask[i]) begin
                v = {8'h00, ref_mem[p[7:0]]};
                p = p + 16'd1;
                if (i >= 4) begin
                    v = {v[7:0], ref_mem[p[7:0]]}; // high byte came first
                    p = p + 16'd1;
                end
                case (i)
                    7:       m.pc_out = v;
                    6:       if (c.ussel) m.s = v; else m.u = v;
                    5:       m.y  = v;
                    4:       m.x  = v;
                    3:       m.dp = v[7:0];
                    2:       m.b  = v[7:0];
                    1:       m.a  = v[7:0];
                    default: m.cc = v[7:0];
                endcase
            end
        end
        if (c.ussel) m.u = p;
        else         m.s = p;
    endtask

    task automatic check_val(string name, logic [15:0] expv, logic [15:0] actv);
        assert (actv === expv) else begin
            $display("ERROR %0t %s expected %h got %h", $time, name, expv, actv);
            errors++;
        end
    endtask

    task automatic check_regs();
        check_val("regs.a", {8'h00, m.a}, {8'h00, regs.a});
        check_val("regs.b", {8'h00, m.b}, {8'h00, regs.b});
        check_val("regs.dp", {8'h00, m.dp}, {8'h00, regs.dp});
        check_val("regs.cc", {8'h00, m.cc}, {8'h00, regs.cc});
        check_val("regs.x", m.x, regs.x);
        check_val("regs.y", m.y, regs.y);
        check_val("regs.u", m.u, regs.u);
        check_val("regs.s", m.s, regs.s);
        check_val("regs.pc_out", m.pc_out, regs.pc_out);
    endtask

    // start on a falling edge and wait for busy to drop
    task automatic run_cmd(kcpu_pkg::kcpu_cmd_t c, logic poke);
        kcpu_pkg::kcpu_cmd_t stray;
        stray      = mk_cmd(kcpu_pkg::CMD_PULL, 0, 0, 16'h0000);
        stray.mask = 8'h01; // would turn the walker around if taken
        wr_addr_q.delete();
        wr_data_q.delete();
        cmd   = c;
        start = 1'b1;
        @(negedge clk);
        busy_clks = 0;
        check_val("busy", 16'h0001, {15'h0000, busy});
        while (busy === 1'b1) begin
            start = poke && busy_clks == 2; // this start must be dropped
            if (start) cmd = stray;
            @(negedge clk);
            busy_clks++;
        end
        start = 1'b0;
    endtask

    task automatic one_shot(kcpu_pkg::kcpu_cmd_t c);
        run_cmd(c, 1'b0);
        model_one_shot(c);
        assert (busy_clks >= 1 && busy_clks <= `KCPU_CEN_DIV) else begin
            $display("one-shot command kept busy for %0d clocks at %0t", busy_clks, $time);
            errors++;
        end
        check_regs();
    endtask

    task automatic stack_op(kcpu_pkg::cmd_kind_e kind, kcpu_pkg::psh_mask_t k,
                            logic us, logic poke);
        kcpu_pkg::kcpu_cmd_t c;
        int                  n;
        c       = mk_cmd(kind, 0, 0, 16'h0000);
        c.mask  = k;
        c.ussel = us;
        n       = byte_count(k);
        exp_addr_q.delete();
        exp_data_q.delete();
        run_cmd(c, poke);
        if (kind == kcpu_pkg::CMD_PUSH) model_push(c);
        else                            model_pull(c);
        assert (busy_clks >= n * `KCPU_CEN_DIV + 1 && busy_clks <= (n + 1) * `KCPU_CEN_DIV)
            else begin
                $display("busy lasted %0d clocks for %0d bytes at %0t", busy_clks, n, $time);
                errors++;
            end
        check_val("write count", 16'(exp_addr_q.size()), 16'(wr_addr_q.size()));
        for (int i = 0; i < exp_addr_q.size() && i < wr_addr_q.size(); i++) begin
            check_val("mem_addr", exp_addr_q[i], wr_addr_q[i]);
            check_val("mem_wdata", {8'h00, exp_data_q[i]}, {8'h00, wr_data_q[i]});
        end
        check_regs();
    endtask

    task automatic load_reg(int code, kcpu_pkg::word_t data);
        one_shot(mk_cmd(kcpu_pkg::CMD_LOAD, code, 0, data));
    endtask

    task automatic step_reg(int code, logic post, logic word);
        kcpu_pkg::kcpu_cmd_t c;
        c          = mk_cmd(kcpu_pkg::CMD_IDX, code, 0, 16'h0000);
        c.idx_post = post;
        c.idx_word = word;
        one_shot(c);
    endtask

    initial begin
        logic                us;
        kcpu_pkg::psh_mask_t k;
        clk   = 1'b0;
        rst   = 1'b1;
        start = 1'b0;
        cmd   = '0;
        pc    = 16'h0000;
        lfsr  = 32'h8bdf;
        m     = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i]    = fill_byte(8'(i));
            u_mem.mem[i]  = fill_byte(8'(i));
        end
        repeat (4) @(negedge clk);
        check_val("busy", 16'h0000, {15'h0000, busy});
        check_val("mem_we", 16'h0000, {15'h0000, mem_we});
        check_regs();
        rst = 1'b0;
        @(negedge clk);

        for (int r = 0; r < 2; r++)
            for (int c = 0; c < 6; c++) load_reg(c, rand_bits(16));

        // every code pair, 6 and 7 included
        for (int d = 0; d < 8; d++) begin
            for (int c = 0; c < 6; c++) load_reg(c, rand_bits(16));
            for (int s = 0; s < 8; s++) begin
                one_shot(mk_cmd(kcpu_pkg::CMD_TFR, d, s, 16'h0000));
                one_shot(mk_cmd(kcpu_pkg::CMD_EXG, d, s, 16'h0000));
            end
        end

        for (int c = 2; c < 6; c++) begin
            load_reg(c, 16'h0001);
            step_reg(c, 1'b0, 1'b0); // down to zero
            step_reg(c, 1'b0, 1'b1); // wraps to fffe
            step_reg(c, 1'b1, 1'b0);
            step_reg(c, 1'b1, 1'b1); // wraps back to 0001
        end

        // pull the fill pattern so DP and CC get random bytes
        load_reg(4, rand_bits(16));
        stack_op(kcpu_pkg::CMD_PULL, 8'hff, 1'b0, 1'b0);
        for (int r = 0; r < 6; r++) begin
            us = r[0];
            k  = 8'(rand_bits(8));
            pc = rand_bits(16);
            load_reg(us ? 5 : 4, rand_bits(16));
            stack_op(kcpu_pkg::CMD_PUSH, k, us, 1'b0);
            for (int c = 0; c < 6; c++)
                if (c != (us ? 5 : 4)) load_reg(c, rand_bits(16)); // scramble
            pc = rand_bits(16);
            stack_op(kcpu_pkg::CMD_PULL, k, us, 1'b0);
        end
        stack_op(kcpu_pkg::CMD_PUSH, 8'h00, 1'b0, 1'b0);
        stack_op(kcpu_pkg::CMD_PULL, 8'h00, 1'b1, 1'b0);

        for (int i = 0; i < 3; i++) one_shot(mk_cmd(kcpu_pkg::CMD_SETF, 0, 0, rand_bits(16)));
        pc = rand_bits(16);
        stack_op(kcpu_pkg::CMD_PUSH, 8'hff, 1'b0, 1'b1);

        repeat (2) @(negedge clk);
        $display("all checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* kcpu_stack_unit.f */
+incdir+src
src/kcpu_pkg.sv
src/kcpu_cen_timer.sv
src/kcpu_mask_walk.sv
src/kcpu_stack_fsm.sv
src/kcpu_regs.sv
src/kcpu_stack_unit.sv
verif/kcpu_tb_mem.sv
verif/kcpu_stack_unit_tb.sv

/* Makefile */
# Verilator build and run for the kcpu stack unit testbench

VERILATOR  ?= verilator
TB_TOP     ?= kcpu_stack_unit_tb
FLIST      ?= kcpu_stack_unit.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	rm -f $(LOG)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
